// File: Makefile
VERILATOR ?= verilator
TOP       := tb_sysio_region
FILELIST  := filelist.f
FLAGS     := --binary --timing --assert
BUILD_DIR := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
hdl/sysio_pkg.sv
hdl/sysio_addr_decode.sv
hdl/sysio_gpio.sv
hdl/sysio_sysctrl.sv
hdl/sysio_default_slave.sv
hdl/sysio_resp_mux.sv
hdl/sysio_region.sv
tests/tb_sysio_region.sv

// File: hdl/sysio_addr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module sysio_addr_decode #(
  parameter logic [sysio_pkg::ADDR_W-1:0] BASE_GPIO0   = 32'h4001_0000,
  parameter logic [sysio_pkg::ADDR_W-1:0] BASE_GPIO1   = 32'h4001_1000,
  parameter logic [sysio_pkg::ADDR_W-1:0] BASE_SYSCTRL = 32'h4001_F000
) (
  input  wire                            hsel,   // Region select
  input  wire  sysio_pkg::sysio_addr_u   haddr,  // Address phase
  output logic [sysio_pkg::NUM_TGT-1:0]  sel     // One-hot target
);

  // Base pages, offset bits dropped
  localparam logic [sysio_pkg::PAGE_W-1:0] PAGE_GPIO0 =
    BASE_GPIO0[sysio_pkg::ADDR_W-1:sysio_pkg::OFFSET_W];
  localparam logic [sysio_pkg::PAGE_W-1:0] PAGE_GPIO1 =
    BASE_GPIO1[sysio_pkg::ADDR_W-1:sysio_pkg::OFFSET_W];
  localparam logic [sysio_pkg::PAGE_W-1:0] PAGE_SYSCTRL =
    BASE_SYSCTRL[sysio_pkg::ADDR_W-1:sysio_pkg::OFFSET_W];

  logic in_region;    // Top nibble matches
  logic hit_gpio0;
  logic hit_gpio1;
  logic hit_sysctrl;
  logic hit_any;      // Some mapped page

  assign in_region   = (haddr.raw[sysio_pkg::ADDR_W-1 -: 4] == sysio_pkg::REGION_TOP);
  assign hit_gpio0   = in_region && (haddr.f.page == PAGE_GPIO0);
  assign hit_gpio1   = in_region && (haddr.f.page == PAGE_GPIO1);
  assign hit_sysctrl = in_region && (haddr.f.page == PAGE_SYSCTRL);
  assign hit_any     = hit_gpio0 || hit_gpio1 || hit_sysctrl;

  always_comb begin
    sel[sysio_pkg::TGT_GPIO0]   = hsel && hit_gpio0;
    sel[sysio_pkg::TGT_GPIO1]   = hsel && hit_gpio1;
    sel[sysio_pkg::TGT_SYSCTRL] = hsel && hit_sysctrl;
    sel[sysio_pkg::TGT_DEFAULT] = hsel && !hit_any;  // Everything unmapped

    // Overlapping base parameters would show up here
    assert ($onehot0(sel) && (hsel || (sel == '0)))
      else $error("sysio_addr_decode: sel %b not one-hot with hsel %b", sel, hsel);
  end

endmodule

`default_nettype wire

// File: hdl/sysio_default_slave.sv
`timescale 1ns/1ns
`default_nettype none

module sysio_default_slave (
  input  wire        hclk,
  input  wire        rst,
  input  wire        sel,      // Unmapped address
  input  wire        hready,
  input  wire  [1:0] htrans,
  output logic       ready,
  output logic       resp      // High is ERROR
);

  logic trans_req;             // NONSEQ or SEQ accepted

  assign trans_req = sel && hready && htrans[1];

  // {ready, resp}: 10 idle, 01 first ERROR cycle, 11 second ERROR cycle
  always_ff @(posedge hclk) begin
    if (rst) begin
      ready <= 1'b1;
      resp  <= 1'b0;
    end else if (trans_req) begin
      ready <= 1'b0;           // Wait cycle with ERROR
      resp  <= 1'b1;
    end else if (!ready) begin
      ready <= 1'b1;           // Complete the ERROR
      resp  <= 1'b1;
    end else begin
      ready <= 1'b1;
      resp  <= 1'b0;           // IDLE and BUSY get OKAY
    end
  end

  // Two-cycle ERROR shape of AHB-Lite
  assert property (@(posedge hclk) disable iff (rst)
    !ready |-> resp ##1 (ready && resp))
    else $error("sysio_default_slave: ERROR response not two cycles");

endmodule

`default_nettype wire

// File: hdl/sysio_gpio.sv
`timescale 1ns/1ns
`default_nettype none

module sysio_gpio #(
  parameter logic [sysio_pkg::GPIO_W-1:0] ALT_FUNC_MASK = '0  // Pins with a mux
) (
  input  wire                            hclk,
  input  wire                            rst,
  input  wire                            sel,          // From decoder
  input  wire                            hready,
  input  wire  [1:0]                     htrans,
  input  wire                            hwrite,
  input  wire  sysio_pkg::sysio_addr_u   haddr,
  input  wire  [sysio_pkg::DATA_W-1:0]   hwdata,
  output logic                           ready,
  output logic                           resp,
  output logic [sysio_pkg::DATA_W-1:0]   rdata,
  input  wire  [sysio_pkg::GPIO_W-1:0]   port_in,      // Asynchronous pins
  output logic [sysio_pkg::GPIO_W-1:0]   port_out,
  output logic [sysio_pkg::GPIO_W-1:0]   port_outen,
  output logic [sysio_pkg::GPIO_W-1:0]   port_altfunc
);

  logic                             accept;   // Address phase taken
  logic                             wr_q;     // Write pending in data phase
  logic [sysio_pkg::OFFSET_W-1:0]   addr_q;   // Register offset
  logic [sysio_pkg::GPIO_W-1:0]     wdata;    // Low half of hwdata
  logic [sysio_pkg::GPIO_W-1:0]     in_meta;  // First sync stage
  logic [sysio_pkg::GPIO_W-1:0]     in_sync;  // Second sync stage

  assign accept = sel && hready && htrans[1];
  assign wdata  = hwdata[sysio_pkg::GPIO_W-1:0];

  // ------------------------------
  // Address phase
  // ------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      wr_q <= 1'b0;
    end else if (hready) begin
      wr_q <= accept && hwrite;   // Cleared by any other transfer
    end
  end

  always_ff @(posedge hclk) begin
    if (accept) begin
      addr_q <= haddr.f.offset;   // Reads use it too
    end
  end

  // ------------------------------
  // Data phase register writes
  // ------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      port_out     <= '0;
      port_outen   <= '0;
      port_altfunc <= '0;
    end else if (wr_q && hready) begin
      case (addr_q)
        sysio_pkg::GPIO_DATAOUT:  port_out     <= wdata;
        sysio_pkg::GPIO_OUTENSET: port_outen   <= port_outen | wdata;
        sysio_pkg::GPIO_OUTENCLR: port_outen   <= port_outen & ~wdata;
        sysio_pkg::GPIO_ALTFSET:  port_altfunc <= port_altfunc | (wdata & ALT_FUNC_MASK);
        sysio_pkg::GPIO_ALTFCLR:  port_altfunc <= port_altfunc & ~wdata;
        default: ;                // Read-only or unused
      endcase
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge hclk) begin
    if (rst) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= port_in;
      in_sync <= in_meta;
    end
  end

  always_comb begin
    rdata = '0;                   // Unused offsets read zero
    case (addr_q)
      sysio_pkg::GPIO_DATA:     rdata[sysio_pkg::GPIO_W-1:0] = in_sync;
      sysio_pkg::GPIO_DATAOUT:  rdata[sysio_pkg::GPIO_W-1:0] = port_out;
      sysio_pkg::GPIO_OUTENSET,
      sysio_pkg::GPIO_OUTENCLR: rdata[sysio_pkg::GPIO_W-1:0] = port_outen;
      sysio_pkg::GPIO_ALTFSET,
      sysio_pkg::GPIO_ALTFCLR:  rdata[sysio_pkg::GPIO_W-1:0] = port_altfunc;
      default: ;
    endcase
  end

  assign ready = 1'b1;            // Zero wait states
  assign resp  = 1'b0;            // Always OKAY

endmodule

`default_nettype wire

// File: hdl/sysio_pkg.sv
`default_nettype none

package sysio_pkg;

  // ------------------------------
  // Bus and port widths
  // ------------------------------
  localparam int ADDR_W   = 32;                 // AHB address
  localparam int DATA_W   = 32;                 // AHB data
  localparam int GPIO_W   = 16;                 // Pins per port
  localparam int OFFSET_W = 12;                 // 4 KB peripheral page
  localparam int PAGE_W   = ADDR_W - OFFSET_W;  // Page number

  localparam logic [3:0] REGION_TOP = 4'h4;     // Region is 0x4xxx_xxxx

  // One address word, seen whole or split into page and offset
  typedef union packed {
    logic [ADDR_W-1:0] raw;                     // Whole word
    struct packed {
      logic [PAGE_W-1:0]   page;                // Selects the peripheral
      logic [OFFSET_W-1:0] offset;              // Register inside the page
    } f;
  } sysio_addr_u;

  // ------------------------------
  // GPIO register map
  // ------------------------------
  localparam logic [OFFSET_W-1:0] GPIO_DATA     = 12'h000; // Synced inputs
  localparam logic [OFFSET_W-1:0] GPIO_DATAOUT  = 12'h004; // Output value
  localparam logic [OFFSET_W-1:0] GPIO_OUTENSET = 12'h010; // Enable set
  localparam logic [OFFSET_W-1:0] GPIO_OUTENCLR = 12'h014; // Enable clear
  localparam logic [OFFSET_W-1:0] GPIO_ALTFSET  = 12'h018; // Alt func set
  localparam logic [OFFSET_W-1:0] GPIO_ALTFCLR  = 12'h01C; // Alt func clear

  // ------------------------------
  // System controller register map
  // ------------------------------
  localparam logic [OFFSET_W-1:0] SYSCTRL_REMAP   = 12'h000; // Boot remap
  localparam logic [OFFSET_W-1:0] SYSCTRL_PMUCTRL = 12'h004; // PMU enable
  localparam logic [OFFSET_W-1:0] SYSCTRL_RESETOP = 12'h008; // Reset on lockup
  localparam logic [OFFSET_W-1:0] SYSCTRL_RSTINFO = 12'h010; // Reset cause, W1C

  // Bit positions in the one-hot target select
  localparam int TGT_GPIO0   = 0;
  localparam int TGT_GPIO1   = 1;
  localparam int TGT_SYSCTRL = 2;
  localparam int TGT_DEFAULT = 3;
  localparam int NUM_TGT     = 4;

endpackage

`default_nettype wire

// File: hdl/sysio_region.sv
`timescale 1ns/1ns
`default_nettype none

module sysio_region #(
  parameter logic [sysio_pkg::ADDR_W-1:0] BASE_GPIO0       = 32'h4001_0000,
  parameter logic [sysio_pkg::ADDR_W-1:0] BASE_GPIO1       = 32'h4001_1000,
  parameter logic [sysio_pkg::ADDR_W-1:0] BASE_SYSCTRL     = 32'h4001_F000,
  parameter logic [sysio_pkg::GPIO_W-1:0] P0_ALT_FUNC_MASK = 16'h0000,  // No pin mux
  parameter logic [sysio_pkg::GPIO_W-1:0] P1_ALT_FUNC_MASK = 16'h002A   // Pins 1, 3, 5
) (
  input  wire                           hclk,
  input  wire                           rst,
  input  wire                           hsel,
  input  wire  sysio_pkg::sysio_addr_u  haddr,
  input  wire  [1:0]                    htrans,
  input  wire                           hwrite,
  input  wire  [sysio_pkg::DATA_W-1:0]  hwdata,
  input  wire                           hready,
  output wire  [sysio_pkg::DATA_W-1:0]  hrdata,
  output wire                           hresp,
  output wire                           hreadyout,
  input  wire  [sysio_pkg::GPIO_W-1:0]  p0_in,
  output wire  [sysio_pkg::GPIO_W-1:0]  p0_out,
  output wire  [sysio_pkg::GPIO_W-1:0]  p0_outen,
  output wire  [sysio_pkg::GPIO_W-1:0]  p0_altfunc,
  input  wire  [sysio_pkg::GPIO_W-1:0]  p1_in,
  output wire  [sysio_pkg::GPIO_W-1:0]  p1_out,
  output wire  [sysio_pkg::GPIO_W-1:0]  p1_outen,
  output wire  [sysio_pkg::GPIO_W-1:0]  p1_altfunc,
  input  wire                           sys_reset_req,
  input  wire                           lockup,
  output wire                           remap_ctrl,
  output wire                           pmu_enable,
  output wire                           lockup_reset
);

  wire [sysio_pkg::NUM_TGT-1:0] sel;         // One-hot target select
  wire                          gpio0_ready, gpio1_ready, sysctrl_ready, def_ready;
  wire                          gpio0_resp, gpio1_resp, sysctrl_resp, def_resp;
  wire [sysio_pkg::DATA_W-1:0]  gpio0_rdata, gpio1_rdata, sysctrl_rdata;

  sysio_addr_decode #(
    .BASE_GPIO0   (BASE_GPIO0),
    .BASE_GPIO1   (BASE_GPIO1),
    .BASE_SYSCTRL (BASE_SYSCTRL)
  ) u_addr_decode (
    .hsel  (hsel),
    .haddr (haddr),
    .sel   (sel)
  );

  // ------------------------------
  // Targets
  // ------------------------------
  sysio_gpio #(.ALT_FUNC_MASK(P0_ALT_FUNC_MASK)) u_gpio0 (
    .hclk (hclk), .rst (rst), .sel (sel[sysio_pkg::TGT_GPIO0]),
    .hready (hready), .htrans (htrans), .hwrite (hwrite), .haddr (haddr),
    .hwdata (hwdata), .ready (gpio0_ready), .resp (gpio0_resp), .rdata (gpio0_rdata),
    .port_in (p0_in), .port_out (p0_out), .port_outen (p0_outen),
    .port_altfunc (p0_altfunc)
  );

  sysio_gpio #(.ALT_FUNC_MASK(P1_ALT_FUNC_MASK)) u_gpio1 (
    .hclk (hclk), .rst (rst), .sel (sel[sysio_pkg::TGT_GPIO1]),
    .hready (hready), .htrans (htrans), .hwrite (hwrite), .haddr (haddr),
    .hwdata (hwdata), .ready (gpio1_ready), .resp (gpio1_resp), .rdata (gpio1_rdata),
    .port_in (p1_in), .port_out (p1_out), .port_outen (p1_outen),
    .port_altfunc (p1_altfunc)
  );

  sysio_sysctrl u_sysctrl (
    .hclk (hclk), .rst (rst), .sel (sel[sysio_pkg::TGT_SYSCTRL]),
    .hready (hready), .htrans (htrans), .hwrite (hwrite), .haddr (haddr),
    .hwdata (hwdata), .ready (sysctrl_ready), .resp (sysctrl_resp),
    .rdata (sysctrl_rdata), .sys_reset_req (sys_reset_req), .lockup (lockup),
    .remap (remap_ctrl), .pmu_enable (pmu_enable), .lockup_reset (lockup_reset)
  );

  sysio_default_slave u_default_slave (
    .hclk (hclk), .rst (rst), .sel (sel[sysio_pkg::TGT_DEFAULT]),
    .hready (hready), .htrans (htrans), .ready (def_ready), .resp (def_resp)
  );

  sysio_resp_mux u_resp_mux (
    .hclk (hclk), .rst (rst), .sel (sel), .hready (hready),
    .gpio0_ready (gpio0_ready), .gpio0_resp (gpio0_resp), .gpio0_rdata (gpio0_rdata),
    .gpio1_ready (gpio1_ready), .gpio1_resp (gpio1_resp), .gpio1_rdata (gpio1_rdata),
    .sysctrl_ready (sysctrl_ready), .sysctrl_resp (sysctrl_resp),
    .sysctrl_rdata (sysctrl_rdata), .def_ready (def_ready), .def_resp (def_resp),
    .hreadyout (hreadyout), .hresp (hresp), .hrdata (hrdata)
  );

endmodule

`default_nettype wire

// File: hdl/sysio_resp_mux.sv
`timescale 1ns/1ns
`default_nettype none

module sysio_resp_mux (
  input  wire                            hclk,
  input  wire                            rst,
  input  wire  [sysio_pkg::NUM_TGT-1:0]  sel,           // Address-phase select
  input  wire                            hready,
  input  wire                            gpio0_ready,
  input  wire                            gpio0_resp,
  input  wire  [sysio_pkg::DATA_W-1:0]   gpio0_rdata,
  input  wire                            gpio1_ready,
  input  wire                            gpio1_resp,
  input  wire  [sysio_pkg::DATA_W-1:0]   gpio1_rdata,
  input  wire                            sysctrl_ready,
  input  wire                            sysctrl_resp,
  input  wire  [sysio_pkg::DATA_W-1:0]   sysctrl_rdata,
  input  wire                            def_ready,
  input  wire                            def_resp,
  output logic                           hreadyout,
  output logic                           hresp,
  output logic [sysio_pkg::DATA_W-1:0]   hrdata
);

  logic [sysio_pkg::NUM_TGT-1:0] owner_q;  // Data-phase target

  always_ff @(posedge hclk) begin
    if (rst) begin
      owner_q <= '0;
    end else if (hready) begin
      owner_q <= sel;                      // Held through waits
    end
  end

  always_comb begin
    hreadyout = 1'b1;                      // No owner, OKAY
    hresp     = 1'b0;
    hrdata    = '0;
    if (owner_q[sysio_pkg::TGT_GPIO0]) begin
      hreadyout = gpio0_ready;
      hresp     = gpio0_resp;
      hrdata    = gpio0_rdata;
    end else if (owner_q[sysio_pkg::TGT_GPIO1]) begin
      hreadyout = gpio1_ready;
      hresp     = gpio1_resp;
      hrdata    = gpio1_rdata;
    end else if (owner_q[sysio_pkg::TGT_SYSCTRL]) begin
      hreadyout = sysctrl_ready;
      hresp     = sysctrl_resp;
      hrdata    = sysctrl_rdata;
    end else if (owner_q[sysio_pkg::TGT_DEFAULT]) begin
      hreadyout = def_ready;
      hresp     = def_resp;                // No read data
    end
  end

  // Relies on the decoder select staying one-hot
  assert property (@(posedge hclk) disable iff (rst) $onehot0(owner_q))
    else $error("sysio_resp_mux: owner %b not one-hot", owner_q);

endmodule

`default_nettype wire

// File: hdl/sysio_sysctrl.sv
`timescale 1ns/1ns
`default_nettype none

module sysio_sysctrl (
  input  wire                            hclk,
  input  wire                            rst,
  input  wire                            sel,
  input  wire                            hready,
  input  wire  [1:0]                     htrans,
  input  wire                            hwrite,
  input  wire  sysio_pkg::sysio_addr_u   haddr,
  input  wire  [sysio_pkg::DATA_W-1:0]   hwdata,
  output logic                           ready,
  output logic                           resp,
  output logic [sysio_pkg::DATA_W-1:0]   rdata,
  input  wire                            sys_reset_req,  // CPU reset request
  input  wire                            lockup,         // CPU locked up
  output logic                           remap,
  output logic                           pmu_enable,
  output logic                           lockup_reset
);

  logic                             accept;
  logic                             wr_q;         // Write pending
  logic [sysio_pkg::OFFSET_W-1:0]   addr_q;
  logic                             wr_en;        // Write lands this cycle
  logic [1:0]                       rstinfo;      // {lockup, sysresetreq}
  logic [1:0]                       rstinfo_clr;  // W1C mask

  assign accept = sel && hready && htrans[1];
  assign wr_en  = wr_q && hready;

  always_ff @(posedge hclk) begin
    if (rst) begin
      wr_q <= 1'b0;
    end else if (hready) begin
      wr_q <= accept && hwrite;
    end
  end

  always_ff @(posedge hclk) begin
    if (accept) begin
      addr_q <= haddr.f.offset;
    end
  end

  // ------------------------------
  // Control bits
  // ------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      remap        <= 1'b0;
      pmu_enable   <= 1'b0;
      lockup_reset <= 1'b0;
    end else if (wr_en) begin
      case (addr_q)
        sysio_pkg::SYSCTRL_REMAP:   remap        <= hwdata[0];
        sysio_pkg::SYSCTRL_PMUCTRL: pmu_enable   <= hwdata[0];
        sysio_pkg::SYSCTRL_RESETOP: lockup_reset <= hwdata[0];
        default: ;
      endcase
    end
  end

  // New events win over a clear in the same cycle
  assign rstinfo_clr = (wr_en && (addr_q == sysio_pkg::SYSCTRL_RSTINFO)) ? hwdata[1:0] : 2'b00;

  always_ff @(posedge hclk) begin
    if (rst) begin
      rstinfo <= 2'b00;
    end else begin
      rstinfo <= (rstinfo & ~rstinfo_clr) | {lockup, sys_reset_req};  // Sticky
    end
  end

  always_comb begin
    rdata = '0;
    case (addr_q)
      sysio_pkg::SYSCTRL_REMAP:   rdata[0]   = remap;
      sysio_pkg::SYSCTRL_PMUCTRL: rdata[0]   = pmu_enable;
      sysio_pkg::SYSCTRL_RESETOP: rdata[0]   = lockup_reset;
      sysio_pkg::SYSCTRL_RSTINFO: rdata[1:0] = rstinfo;
      default: ;                  // Reads as zero
    endcase
  end

  assign ready = 1'b1;
  assign resp  = 1'b0;

endmodule

`default_nettype wire

// File: tests/tb_sysio_region.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sysio_region;

  localparam int          TIMEOUT_CYCLES = 3000;          // Stimulus needs about 120 cycles
  localparam logic [31:0] GPIO0_BASE     = 32'h4001_0000;
  localparam logic [31:0] GPIO1_BASE     = 32'h4001_1000;
  localparam logic [31:0] SYSCTRL_BASE   = 32'h4001_F000;

  logic                   hclk;
  logic                   rst;
  logic                   hsel;
  sysio_pkg::sysio_addr_u haddr;
  logic [1:0]             htrans;
  logic                   hwrite;
  logic [31:0]            hwdata;
  wire                    hready;
  wire  [31:0]            hrdata;
  wire                    hresp;
  wire                    hreadyout;
  logic [15:0]            p0_in;
  logic [15:0]            p1_in;
  wire  [15:0]            p0_out;
  wire  [15:0]            p0_outen;
  wire  [15:0]            p0_altfunc;
  wire  [15:0]            p1_out;
  wire  [15:0]            p1_outen;
  wire  [15:0]            p1_altfunc;
  logic                   sys_reset_req;
  logic                   lockup;
  wire                    remap_ctrl;
  wire                    pmu_enable;
  wire                    lockup_reset;

  logic [31:0] rand_state = 32'h4ef1_3080;  // LCG state
  int          cycles     = 0;

  assign hready = hreadyout;                // Single master

  sysio_region dut (.*);

  initial begin
    hclk = 1'b0;
    forever #20 hclk = ~hclk;               // 40 ns period
  end

  always @(posedge hclk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles before the tests finished", cycles);
      $display("** FAIL **");
      $fatal(1, "Timeout");
    end
  end

  // ------------------------------
  // Protocol checks
  // ------------------------------
  assert property (@(posedge hclk) disable iff (rst)
    !hreadyout |-> hresp ##1 (hreadyout && hresp))  // Two-cycle ERROR
    else begin
      $display("Wait state without the two-cycle ERROR response at %0t", $time);
      $display("** FAIL **");
      $fatal(1, "Protocol check");
    end

  assert property (@(posedge hclk) rst |=> (hreadyout && !hresp))
    else begin
      $display("Bus response not idle OKAY after reset at %0t", $time);
      $display("** FAIL **");
      $fatal(1, "Reset check");
    end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else begin
        $display("FAILED time %0t %s expected %h actual %h", $time, name, expected, actual);
        $display("** FAIL **");
        $fatal(1, "Value mismatch");
      end
  endtask

  // One NONSEQ transfer between two falling edges
  task automatic ahb_transfer(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output int waits);
    hsel      = 1'b1;
    haddr.raw = addr;
    htrans    = 2'b10;
    hwrite    = wr;
    @(posedge hclk);                        // Address phase taken
    @(negedge hclk);
    hsel   = 1'b0;
    htrans = 2'b00;                         // IDLE behind it
    hwrite = 1'b0;
    hwdata = wdata;
    waits  = 0;
    while (!hreadyout) begin
      waits = waits + 1;
      @(negedge hclk);
    end
    rdata = hrdata;                         // Last data cycle
    err   = hresp;
    @(negedge hclk);
  endtask

  task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    int          waits;
    ahb_transfer(1'b1, addr, data, rd, err, waits);
    check_value("hresp", 0, 32'(err));
    check_value("wait states", 0, waits);
  endtask

  task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
    logic err;
    int   waits;
    ahb_transfer(1'b0, addr, '0, data, err, waits);
    check_value("hresp", 0, 32'(err));
    check_value("wait states", 0, waits);
  endtask

  task automatic expect_error(input logic wr, input logic [31:0] addr);
    logic [31:0] rd;
    logic        err;
    int          waits;
    ahb_transfer(wr, addr, 32'hDEAD_BEEF, rd, err, waits);
    check_value("hresp", 1, 32'(err));
    check_value("wait states", 1, waits);   // One ERROR wait before completion
  endtask

  initial begin : main_seq
    logic [31:0] rd;
    logic [31:0] base;
    logic [15:0] exp_en;
    logic [15:0] last_out1;
    rst           = 1'b1;
    hsel          = 1'b0;
    haddr.raw     = '0;
    htrans        = 2'b00;
    hwrite        = 1'b0;
    hwdata        = '0;
    p0_in         = '0;
    p1_in         = '0;
    sys_reset_req = 1'b0;
    lockup        = 1'b0;
    repeat (16) @(posedge hclk);
    @(negedge hclk);
    rst = 1'b0;

    // Reset state
    check_value("hreadyout", 1, 32'(hreadyout));
    check_value("hresp", 0, 32'(hresp));
    check_value("p0_out", 0, 32'(p0_out));
    check_value("p0_outen", 0, 32'(p0_outen));
    check_value("p0_altfunc", 0, 32'(p0_altfunc));
    check_value("p1_out", 0, 32'(p1_out));
    check_value("p1_outen", 0, 32'(p1_outen));
    check_value("p1_altfunc", 0, 32'(p1_altfunc));
    check_value("remap_ctrl", 0, 32'(remap_ctrl));
    check_value("pmu_enable", 0, 32'(pmu_enable));
    check_value("lockup_reset", 0, 32'(lockup_reset));

    // ------------------------------
    // GPIO data and enables
    // ------------------------------
    for (int p = 0; p < 2; p++) begin
      base       = (p == 0) ? GPIO0_BASE : GPIO1_BASE;
      rand_state = next_random(rand_state);
      ahb_write(base + 32'(sysio_pkg::GPIO_DATAOUT), rand_state);  // Upper half ignored
      last_out1  = rand_state[15:0];
      check_value($sformatf("p%0d_out", p), 32'(rand_state[15:0]),
                  32'((p == 0) ? p0_out : p1_out));
      ahb_read(base + 32'(sysio_pkg::GPIO_DATAOUT), rd);
      check_value("hrdata", 32'(rand_state[15:0]), rd);
      exp_en = '0;
      for (int k = 0; k < 3; k++) begin
        rand_state = next_random(rand_state);
        if (k < 2) begin
          ahb_write(base + 32'(sysio_pkg::GPIO_OUTENSET), rand_state);
          exp_en = exp_en | rand_state[15:0];
        end else begin
          ahb_write(base + 32'(sysio_pkg::GPIO_OUTENCLR), rand_state);
          exp_en = exp_en & ~rand_state[15:0];
        end
        check_value($sformatf("p%0d_outen", p), 32'(exp_en),
                    32'((p == 0) ? p0_outen : p1_outen));
        ahb_read(base + 32'(sysio_pkg::GPIO_OUTENCLR), rd);
        check_value("hrdata", 32'(exp_en), rd);
      end
    end

    // Only masked pins take an alternate function
    ahb_write(GPIO0_BASE + 32'(sysio_pkg::GPIO_ALTFSET), 32'hFFFF_FFFF);
    ahb_write(GPIO1_BASE + 32'(sysio_pkg::GPIO_ALTFSET), 32'hFFFF_FFFF);
    check_value("p0_altfunc", 32'h0000, 32'(p0_altfunc));
    check_value("p1_altfunc", 32'h002A, 32'(p1_altfunc));
    ahb_read(GPIO1_BASE + 32'(sysio_pkg::GPIO_ALTFSET), rd);
    check_value("hrdata", 32'h002A, rd);
    ahb_write(GPIO0_BASE + 32'(sysio_pkg::GPIO_ALTFCLR), 32'hFFFF_FFFF);
    ahb_write(GPIO1_BASE + 32'(sysio_pkg::GPIO_ALTFCLR), 32'hFFFF_FFFF);
    check_value("p0_altfunc", 0, 32'(p0_altfunc));
    check_value("p1_altfunc", 0, 32'(p1_altfunc));

    // Input pins through the synchronizer
    rand_state = next_random(rand_state);
    p0_in      = rand_state[15:0];
    p1_in      = rand_state[31:16];
    repeat (3) @(negedge hclk);
    ahb_read(GPIO0_BASE + 32'(sysio_pkg::GPIO_DATA), rd);
    check_value("hrdata", 32'(rand_state[15:0]), rd);
    ahb_read(GPIO1_BASE + 32'(sysio_pkg::GPIO_DATA), rd);
    check_value("hrdata", 32'(rand_state[31:16]), rd);

    // ------------------------------
    // System controller
    // ------------------------------
    ahb_write(SYSCTRL_BASE + 32'(sysio_pkg::SYSCTRL_REMAP), 1);
    ahb_write(SYSCTRL_BASE + 32'(sysio_pkg::SYSCTRL_PMUCTRL), 1);
    ahb_write(SYSCTRL_BASE + 32'(sysio_pkg::SYSCTRL_RESETOP), 1);
    check_value("remap_ctrl", 1, 32'(remap_ctrl));
    check_value("pmu_enable", 1, 32'(pmu_enable));
    check_value("lockup_reset", 1, 32'(lockup_reset));
    ahb_read(SYSCTRL_BASE + 32'(sysio_pkg::SYSCTRL_RSTINFO), rd);
    check_value("hrdata", 0, rd);
    sys_reset_req = 1'b1;                   // One-cycle pulse
    @(negedge hclk);
    sys_reset_req = 1'b0;
    ahb_read(SYSCTRL_BASE + 32'(sysio_pkg::SYSCTRL_RSTINFO), rd);
    check_value("hrdata", 32'h1, rd);
    lockup = 1'b1;
    @(negedge hclk);
    lockup = 1'b0;
    ahb_read(SYSCTRL_BASE + 32'(sysio_pkg::SYSCTRL_RSTINFO), rd);
    check_value("hrdata", 32'h3, rd);
    ahb_write(SYSCTRL_BASE + 32'(sysio_pkg::SYSCTRL_RSTINFO), 32'h1);  // W1C one bit
    ahb_read(SYSCTRL_BASE + 32'(sysio_pkg::SYSCTRL_RSTINFO), rd);
    check_value("hrdata", 32'h2, rd);
    ahb_write(SYSCTRL_BASE + 32'(sysio_pkg::SYSCTRL_RSTINFO), 32'h2);
    ahb_read(SYSCTRL_BASE + 32'(sysio_pkg::SYSCTRL_RSTINFO), rd);
    check_value("hrdata", 0, rd);

    // Unmapped pages
    expect_error(1'b1, 32'h4000_0000);
    expect_error(1'b0, 32'h4000_0000);
    expect_error(1'b0, 32'h4001_2000);
    expect_error(1'b1, 32'h4FFF_F000);
    ahb_read(GPIO1_BASE + 32'(sysio_pkg::GPIO_DATAOUT), rd);  // Back to OKAY
    check_value("hrdata", 32'(last_out1), rd);

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
